// ==== include/merge_settings.svh ====
`ifndef MERGE_SETTINGS_SVH
`define MERGE_SETTINGS_SVH

// keys per beat, lane 0 carries the smallest key
`define MERGE_LANES 4

`define KEY_WIDTH 32   // unsigned keys, zero marks the end of a run

`define FIFO_DEPTH 16  // power of two only

`endif

// ==== source/merge_pkg.sv ====
`include "merge_settings.svh"

package merge_pkg;

   typedef logic [`KEY_WIDTH-1:0] key_t;

   // lanes rise in key value, lane 0 is the head key of the beat
   typedef key_t [`MERGE_LANES-1:0] beat_t;

   typedef logic [$clog2(`FIFO_DEPTH):0] count_t;  // fill count, one bit wider than a pointer

   typedef enum logic [2:0] {
      ST_MERGE,
      ST_DRAIN_A,
      ST_DRAIN_B,
      ST_FLUSH,
      ST_END
   } merge_state_t;

endpackage

// ==== source/beat_fifo.sv ====
`timescale 1ns/1ps
`include "merge_settings.svh"

module beat_fifo
   import merge_pkg::*;
(
   input  logic   i_clk,
   input  logic   i_rst,
   input  logic   i_enq,
   input  logic   i_deq,
   input  beat_t  i_data,
   output beat_t  o_data,
   output logic   o_empty,
   output logic   o_full,
   output count_t o_count
);

   localparam int PTR_W = $clog2(`FIFO_DEPTH);

   beat_t            mem [`FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   count_t           count;

   always_ff @(posedge i_clk) begin
      if (i_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_enq) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (i_deq) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({i_enq, i_deq})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // idle, or enqueue and dequeue together
         endcase
      end
   end

   assign o_data  = mem[rd_ptr];  // head is visible without a read
   assign o_empty = (count == '0);
   assign o_full  = (count == count_t'(`FIFO_DEPTH));
   assign o_count = count;

   // the writer upstream must honour o_full
   a_no_overrun: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_enq && o_full));

   // and the reader must honour o_empty
   a_no_underrun: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_deq && o_empty));

endmodule

// ==== source/bitonic_merge_net.sv ====
`timescale 1ns/1ps
`include "merge_settings.svh"

module bitonic_merge_net
   import merge_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_rst,
   input  logic  i_load,
   input  beat_t i_new_beat,
   output beat_t o_low_beat,
   output logic  o_low_valid,
   output beat_t o_high_beat
);

   localparam int LANES  = `MERGE_LANES;
   localparam int N      = 2 * LANES;
   localparam int LEVELS = $clog2(N);

   wire key_t net [LEVELS+1][N];
   beat_t     merged_low;
   beat_t     merged_high;
   logic      new_is_term;

   // new beat rises, reversed high beat falls, so the pair is bitonic
   for (genvar i = 0; i < LANES; i++) begin : g_in
      assign net[0][i]       = i_new_beat[i];
      assign net[0][N-1-i]   = o_high_beat[i];
   end

   // half cleaners with distance N/2 down to 1
   for (genvar lv = 0; lv < LEVELS; lv++) begin : g_level
      localparam int DIST = N >> (lv + 1);
      for (genvar i = 0; i < N; i++) begin : g_cx
         if ((i & DIST) == 0) begin : g_pair
            assign net[lv+1][i] = (net[lv][i] <= net[lv][i+DIST]) ?
                                  net[lv][i] : net[lv][i+DIST];
            assign net[lv+1][i+DIST] = (net[lv][i] <= net[lv][i+DIST]) ?
                                       net[lv][i+DIST] : net[lv][i];
         end
      end
   end

   for (genvar i = 0; i < LANES; i++) begin : g_out
      assign merged_low[i]  = net[LEVELS][i];
      assign merged_high[i] = net[LEVELS][LANES+i];
   end

   assign new_is_term = (i_new_beat[0] == '0);

   // a zero low half only appears while the retained beat is still empty
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_low_valid <= 1'b0;
         o_high_beat <= '0;
      end else begin
         o_low_valid <= i_load && (merged_low[0] != '0);
         if (i_load) begin
            o_high_beat <= new_is_term ? '0 : merged_high;  // terminator clears the retained beat
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_load) begin
         o_low_beat <= merged_low;
      end
   end

endmodule

// ==== source/merge_control.sv ====
`timescale 1ns/1ps
`include "merge_settings.svh"

module merge_control
   import merge_pkg::*;
(
   input  logic         i_clk,
   input  logic         i_rst,
   input  beat_t        i_head_a,
   input  beat_t        i_head_b,
   input  logic         i_empty_a,
   input  logic         i_empty_b,
   input  count_t       i_out_count,
   input  logic         i_high_zero,
   output logic         o_take_a,
   output logic         o_take_b,
   output logic         o_flush,
   output logic         o_end,
   output merge_state_t o_state
);

   merge_state_t state;
   merge_state_t state_nxt;
   logic         stall;
   logic         a_term;
   logic         b_term;
   logic [1:0]   take_hist;  // takes of the last two cycles still in the pipeline

   // leaves room for the beats already between a take and the output FIFO
   assign stall  = (i_out_count >= count_t'(`FIFO_DEPTH - 3));
   assign a_term = !i_empty_a && (i_head_a[0] == '0);
   assign b_term = !i_empty_b && (i_head_b[0] == '0);

   always_comb begin
      state_nxt = state;
      o_take_a  = 1'b0;
      o_take_b  = 1'b0;
      o_flush   = 1'b0;
      o_end     = 1'b0;
      case (state)
         ST_MERGE: begin
            if (!i_empty_a && !i_empty_b && !stall) begin
               if (a_term && b_term) state_nxt = ST_FLUSH;
               else if (a_term) state_nxt = ST_DRAIN_B;
               else if (b_term) state_nxt = ST_DRAIN_A;
               else if (i_head_a[0] <= i_head_b[0]) o_take_a = 1'b1;  // ties go to a
               else o_take_b = 1'b1;
            end
         end
         ST_DRAIN_A: begin
            if (!i_empty_a && !stall) begin
               if (a_term) state_nxt = ST_FLUSH;
               else o_take_a = 1'b1;
            end
         end
         ST_DRAIN_B: begin
            if (!i_empty_b && !stall) begin
               if (b_term) state_nxt = ST_FLUSH;
               else o_take_b = 1'b1;
            end
         end
         ST_FLUSH: begin
            // the retained beat is final once the last take has passed the network
            if (take_hist == 2'b00 && !stall) begin
               o_flush   = !i_high_zero;
               state_nxt = ST_END;
            end
         end
         ST_END: begin
            if (!stall) begin
               o_end     = 1'b1;  // both terminators leave together
               state_nxt = ST_MERGE;
            end
         end
         default: state_nxt = ST_MERGE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state     <= ST_MERGE;
         take_hist <= 2'b00;
      end else begin
         state     <= state_nxt;
         take_hist <= {take_hist[0], o_take_a | o_take_b};
      end
   end

   assign o_state = state;

endmodule

// ==== source/run_merger.sv ====
`timescale 1ns/1ps
`include "merge_settings.svh"

module run_merger
   import merge_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_rst,
   input  beat_t i_src_a_beat,
   input  beat_t i_src_b_beat,
   input  logic  i_src_a_empty,
   input  logic  i_src_b_empty,
   output logic  o_src_a_read,
   output logic  o_src_b_read,
   input  logic  i_out_read,
   output beat_t o_out_beat,
   output logic  o_out_empty
);

   beat_t        head_a, head_b;
   logic         empty_a, empty_b;
   logic         full_a, full_b;
   logic         take_a, take_b;
   logic         flush, fin;
   merge_state_t state;
   beat_t        sel_beat;
   logic         sel_valid;
   beat_t        low_beat, high_beat;
   logic         low_valid;
   beat_t        out_wr_beat;
   logic         out_wr;
   count_t       out_count;
   key_t         last_key;
   logic         rst_q;

   // sources are left alone through reset and the cycle after it
   always_ff @(posedge i_clk) begin
      rst_q <= i_rst;
   end

   // the read strobe of a source is also the write of its FIFO
   assign o_src_a_read = !i_rst && !rst_q && !i_src_a_empty && !full_a;
   assign o_src_b_read = !i_rst && !rst_q && !i_src_b_empty && !full_b;

   beat_fifo fifo_a (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_enq(o_src_a_read), .i_deq(take_a | fin),
      .i_data(i_src_a_beat), .o_data(head_a),
      .o_empty(empty_a), .o_full(full_a), .o_count()
   );

   beat_fifo fifo_b (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_enq(o_src_b_read), .i_deq(take_b | fin),
      .i_data(i_src_b_beat), .o_data(head_b),
      .o_empty(empty_b), .o_full(full_b), .o_count()
   );

   merge_control u_control (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_head_a(head_a), .i_head_b(head_b),
      .i_empty_a(empty_a), .i_empty_b(empty_b),
      .i_out_count(out_count), .i_high_zero(high_beat == '0),
      .o_take_a(take_a), .o_take_b(take_b),
      .o_flush(flush), .o_end(fin), .o_state(state)
   );

   always_ff @(posedge i_clk) begin
      if (i_rst) sel_valid <= 1'b0;
      else sel_valid <= take_a | take_b | fin;
   end

   // on fin a zero beat goes in so the network drops its retained beat
   always_ff @(posedge i_clk) begin
      if (take_a) sel_beat <= head_a;
      else if (take_b) sel_beat <= head_b;
      else if (fin) sel_beat <= '0;
   end

   bitonic_merge_net u_net (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_load(sel_valid), .i_new_beat(sel_beat),
      .o_low_beat(low_beat), .o_low_valid(low_valid),
      .o_high_beat(high_beat)
   );

   // flush and fin only come once the pipeline is empty, so no write collides
   always_comb begin
      if (fin) out_wr_beat = '0;
      else if (flush) out_wr_beat = high_beat;
      else out_wr_beat = low_beat;
   end
   assign out_wr = low_valid | flush | fin;

   beat_fifo fifo_out (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_enq(out_wr), .i_deq(i_out_read),
      .i_data(out_wr_beat), .o_data(o_out_beat),
      .o_empty(o_out_empty), .o_full(), .o_count(out_count)
   );

   always_ff @(posedge i_clk) begin
      if (i_rst) last_key <= '0;
      else if (out_wr) last_key <= fin ? '0 : out_wr_beat[`MERGE_LANES-1];
   end

   // beats of one output run never step down in key value
   a_run_sorted: assert property (@(posedge i_clk) disable iff (i_rst)
      (out_wr && state != ST_END) |-> (out_wr_beat[0] >= last_key));

endmodule

// ==== source/merge_tree.sv ====
`timescale 1ns/1ps

module merge_tree
   import merge_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rst,
   input  beat_t      i_src_beat [4],
   input  logic [3:0] i_src_empty,
   output logic [3:0] o_src_read,
   input  logic       i_out_ready,
   output beat_t      o_out_beat,
   output logic       o_out_write
);

   beat_t      leaf_beat [2];
   logic [1:0] leaf_empty;
   logic [1:0] leaf_read;
   logic       root_empty;

   run_merger u_leaf0 (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_src_a_beat(i_src_beat[0]), .i_src_b_beat(i_src_beat[1]),
      .i_src_a_empty(i_src_empty[0]), .i_src_b_empty(i_src_empty[1]),
      .o_src_a_read(o_src_read[0]), .o_src_b_read(o_src_read[1]),
      .i_out_read(leaf_read[0]), .o_out_beat(leaf_beat[0]), .o_out_empty(leaf_empty[0])
   );

   run_merger u_leaf1 (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_src_a_beat(i_src_beat[2]), .i_src_b_beat(i_src_beat[3]),
      .i_src_a_empty(i_src_empty[2]), .i_src_b_empty(i_src_empty[3]),
      .o_src_a_read(o_src_read[2]), .o_src_b_read(o_src_read[3]),
      .i_out_read(leaf_read[1]), .o_out_beat(leaf_beat[1]), .o_out_empty(leaf_empty[1])
   );

   // each leaf output FIFO looks like a plain source to the root
   run_merger u_root (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_src_a_beat(leaf_beat[0]), .i_src_b_beat(leaf_beat[1]),
      .i_src_a_empty(leaf_empty[0]), .i_src_b_empty(leaf_empty[1]),
      .o_src_a_read(leaf_read[0]), .o_src_b_read(leaf_read[1]),
      .i_out_read(o_out_write), .o_out_beat(o_out_beat), .o_out_empty(root_empty)
   );

   assign o_out_write = i_out_ready && !root_empty;  // a low ready just holds the head

endmodule

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
   parameter int HALF_PERIOD = 5,
   parameter int RESET_CYCLES = 8
) (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      o_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_rst <= 1'b0;  // released on an edge like any other driven input
   end

   always #HALF_PERIOD o_clk = ~o_clk;

endmodule

// ==== verification/merge_tree_tb.sv ====
`timescale 1ns/1ps
`include "merge_settings.svh"

module merge_tree_tb
   import merge_pkg::*;
();

   localparam int LANES = `MERGE_LANES;

   typedef key_t  key_q_t[$];
   typedef beat_t beat_q_t[$];

   logic       clk;
   logic       rst;
   beat_t      src_beat [4];
   logic [3:0] src_empty;
   logic [3:0] src_read;
   logic       out_ready;
   beat_t      out_beat;
   logic       out_write;

   beat_q_t     src_q [4];   // one upstream FIFO per source holding all rounds back to back
   beat_q_t     exp_q;
   logic [31:0] key_rng     = 32'd12339;
   logic [31:0] ready_rng   = 32'd12339;
   logic        ready_random = 1'b0;
   logic        rst_seen    = 1'b1;
   int          beats_queued = 0;
   int          cycle_count = 0;
   int          errors      = 0;

   clock_gen u_clock (.o_clk(clk), .o_rst(rst));

   merge_tree i_dut (
      .i_clk(clk), .i_rst(rst),
      .i_src_beat(src_beat), .i_src_empty(src_empty), .o_src_read(src_read),
      .i_out_ready(out_ready), .o_out_beat(out_beat), .o_out_write(out_write)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      key_rng = xorshift32(key_rng);
      return key_rng;
   endfunction

   // mode 1 draws from a few values so that keys repeat across sources and hit the maximum
   function automatic key_t next_key(input int mode);
      key_t k;
      k = next_random();
      if (mode == 1) begin
         case (k[2:0])
            3'd0, 3'd1:       k = 32'd1;
            3'd2, 3'd3, 3'd4: k = 32'd5;
            3'd5:             k = 32'hffff_fffe;
            default:          k = 32'hffff_ffff;
         endcase
      end
      if (k == '0) k = 32'd1;  // zero is the terminator
      return k;
   endfunction

   function automatic int random_len(input int lo, input int hi);
      return lo + int'(next_random() % (hi - lo + 1));
   endfunction

   function automatic key_q_t sort_keys(input key_q_t q);
      key_q_t s;
      key_t   tmp;
      int     i;
      int     j;
      s = q;
      for (i = 1; i < s.size(); i++) begin
         tmp = s[i];
         j = i - 1;
         while (j >= 0 && s[j] > tmp) begin
            s[j+1] = s[j];
            j--;
         end
         s[j+1] = tmp;
      end
      return s;
   endfunction

   // expected output of one round is all keys in rising order then one terminator
   function automatic beat_q_t merge_reference(input key_q_t r0, input key_q_t r1,
                                               input key_q_t r2, input key_q_t r3);
      key_q_t  all;
      beat_q_t beats;
      beat_t   b;
      int      i;
      int      l;
      foreach (r0[k]) all.push_back(r0[k]);
      foreach (r1[k]) all.push_back(r1[k]);
      foreach (r2[k]) all.push_back(r2[k]);
      foreach (r3[k]) all.push_back(r3[k]);
      all = sort_keys(all);
      for (i = 0; i < all.size(); i += LANES) begin
         for (l = 0; l < LANES; l++) b[l] = all[i+l];
         beats.push_back(b);
      end
      beats.push_back('0);
      return beats;
   endfunction

   task automatic report_failure(input string what);
      errors++;
      $display("%s", what);
      $display("test failed");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check_beat(input string name, input beat_t actual, input beat_t expected);
      if (actual !== expected) begin
         report_failure($sformatf("error %s expected %h actual %h", name, expected, actual));
      end
   endtask

   task automatic check_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         report_failure($sformatf("error %s expected %h actual %h", name, expected, actual));
      end
   endtask

   task automatic queue_round(input int len0, input int len1, input int len2, input int len3,
                              input int mode);
      int      lens [4];
      key_q_t  runs [4];
      beat_q_t expected;
      beat_t   b;
      int      n;
      int      k;
      int      l;
      lens = '{len0, len1, len2, len3};
      for (n = 0; n < 4; n++) begin
         for (k = 0; k < lens[n] * LANES; k++) runs[n].push_back(next_key(mode));
         runs[n] = sort_keys(runs[n]);
         for (k = 0; k < lens[n]; k++) begin
            for (l = 0; l < LANES; l++) b[l] = runs[n][k*LANES + l];
            src_q[n].push_back(b);
         end
         src_q[n].push_back('0);
         beats_queued += lens[n] + 1;
      end
      expected = merge_reference(runs[0], runs[1], runs[2], runs[3]);
      foreach (expected[i]) exp_q.push_back(expected[i]);
      beats_queued += expected.size();
   endtask

   task automatic wait_for_drain();
      while (exp_q.size() != 0) @(negedge clk);
   endtask

   // each source shows its head and a read pops it so the next head follows one edge later
   always @(posedge clk) begin
      int n;
      for (n = 0; n < 4; n++) begin
         if (src_read[n]) begin
            if (src_empty[n]) report_failure($sformatf("source %0d was read while empty", n));
            else void'(src_q[n].pop_front());
         end
         if (src_q[n].size() != 0) begin
            src_beat[n]  <= src_q[n][0];
            src_empty[n] <= 1'b0;
         end else begin
            src_beat[n]  <= '0;
            src_empty[n] <= 1'b1;
         end
      end
   end

   always @(posedge clk) begin
      if (ready_random) begin
         ready_rng = xorshift32(ready_rng);
         out_ready <= ready_rng[4];
      end else begin
         out_ready <= 1'b1;
      end
   end

   always @(posedge clk) begin
      int n;
      rst_seen <= rst;
      if (rst || rst_seen) begin
         for (n = 0; n < 4; n++) check_bit($sformatf("o_src_read[%0d]", n), src_read[n], 1'b0);
         check_bit("o_out_write", out_write, 1'b0);
      end else begin
         // a write without ready, or with nothing left to expect, is a fault
         if (!out_ready || exp_q.size() == 0) check_bit("o_out_write", out_write, 1'b0);
         if (out_write) check_beat("o_out_beat", out_beat, exp_q.pop_front());
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > 40 * beats_queued + 500) begin
         report_failure($sformatf("timeout after %0d cycles with %0d beats still expected",
                                  cycle_count, exp_q.size()));
      end
   end

   initial begin
      int r;
      src_empty = 4'hf;
      src_beat  = '{default: '0};
      out_ready = 1'b0;

      // the first round already waits in the sources while reset is asserted
      queue_round(random_len(1, 10), random_len(1, 10), random_len(1, 10), random_len(1, 10), 0);
      wait_for_drain();

      ready_random = 1'b1;
      for (r = 0; r < 2; r++) begin
         queue_round(random_len(0, 10), random_len(0, 10), random_len(0, 10),
                     random_len(0, 10), 0);
      end
      wait_for_drain();

      ready_random = 1'b0;
      queue_round(0, random_len(1, 10), random_len(1, 10), random_len(1, 10), 0);
      queue_round(random_len(1, 10), 0, 0, random_len(1, 10), 0);
      queue_round(random_len(1, 10), random_len(1, 10), 0, 0, 0);
      queue_round(0, 0, 0, 0, 0);
      wait_for_drain();

      queue_round(random_len(1, 10), random_len(1, 10), random_len(1, 10), random_len(1, 10), 1);
      queue_round(random_len(0, 10), random_len(0, 10), random_len(0, 10), random_len(0, 10), 1);
      wait_for_drain();

      ready_random = 1'b1;
      for (r = 0; r < 5; r++) begin
         queue_round(random_len(0, 10), random_len(0, 10), random_len(0, 10),
                     random_len(0, 10), 0);
      end
      wait_for_drain();

      repeat (50) @(negedge clk);  // any late extra beat shows up here
      for (r = 0; r < 4; r++) begin
         if (src_q[r].size() != 0) report_failure($sformatf("source %0d was not fully read", r));
      end

      if (errors == 0) begin
         $display("test passed");
         $finish;
      end else begin
         $display("test failed");
         $fatal(1, "checks failed");
      end
   end

endmodule

// ==== files.f ====
+incdir+include
source/merge_pkg.sv
source/beat_fifo.sv
source/bitonic_merge_net.sv
source/merge_control.sv
source/run_merger.sv
source/merge_tree.sv
verification/clock_gen.sv
verification/merge_tree_tb.sv
